//--- ft_alu_cfg.svh
// build constants for the ft alu stage; the code assumes four replicas with replica 3 as the spare
`ifndef FT_ALU_CFG_SVH
`define FT_ALU_CFG_SVH

//////////////////////////////
// datapath
`define FT_XLEN        32    // data word and apb data width
`define FT_NREPL       4     // alu replicas incl. the spare
`define FT_NLANE       3     // voting lanes

//////////////////////////////
// error bookkeeping
`define FT_CNT_W       8     // saturating error counters
`define FT_PERM_THRESH 4     // errors before a replica counts as broken

//////////////////////////////
// apb register map
`define FT_APB_AW      8
`define FT_REG_CNT0    8'h00
`define FT_REG_CNT1    8'h04
`define FT_REG_CNT2    8'h08
`define FT_REG_CNT3    8'h0C
`define FT_REG_STATUS  8'h10 // read only

`endif

//--- ft_alu_pkg.sv
// shared types of the ft alu stage; widths come from ft_alu_cfg.svh and must match its defines
`include "ft_alu_cfg.svh"
`default_nettype none

package ft_alu_pkg;

	//////////////////////////////
	// alu operations, single cycle only
	typedef enum logic [2:0] {
		ADD  = 3'd0,
		SUB  = 3'd1,
		AND  = 3'd2,
		OR   = 3'd3,
		XOR  = 3'd4,
		SLL  = 3'd5, // shift by b[4:0]
		SRL  = 3'd6, // logical
		SLTU = 3'd7  // unsigned set less than
	} alu_op_e;

	//////////////////////////////
	// data and bookkeeping types
	typedef logic [`FT_XLEN-1:0]  word_t;     // operand, result, apb data
	typedef logic [`FT_NREPL-1:0] repl_vec_t; // one bit per physical replica
	typedef logic [`FT_NLANE-1:0] lane_sel_t; // set bit -> lane runs on the spare
	typedef logic [`FT_CNT_W-1:0] cnt_t;      // error count

endpackage : ft_alu_pkg

`default_nettype wire

//--- alu_core.sv
// one alu replica; result is registered on valid_i only, payload regs have no reset and hold X until the first op
`default_nettype none

module alu_core import ft_alu_pkg::*; (
	input  logic    clk_i,
	input  logic    arst_n_i,
	input  logic    valid_i,      // op present this cycle
	input  alu_op_e op_i,
	input  word_t   a_i,
	input  word_t   b_i,
	input  word_t   fault_res_i,  // xor mask on the stored result
	input  logic    fault_cmp_i,  // flips the stored compare flag
	output logic    valid_o,      // one cycle after valid_i
	output word_t   res_o,
	output logic    cmp_o
);

	localparam int SHW = $clog2($bits(word_t)); // shift amount width

	word_t          res_d;
	logic           cmp_d;
	logic           lt_u;
	logic [SHW-1:0] shamt;

	assign shamt = b_i[SHW-1:0];  // upper bits of b ignored for shifts
	assign lt_u  = a_i < b_i;     // word_t is unsigned

	//////////////////////////////
	// combinational alu
	always_comb begin
		case (op_i)
			ADD:     res_d = a_i + b_i;
			SUB:     res_d = a_i - b_i;
			AND:     res_d = a_i & b_i;
			OR:      res_d = a_i | b_i;
			XOR:     res_d = a_i ^ b_i;
			SLL:     res_d = a_i << shamt;
			SRL:     res_d = a_i >> shamt;
			SLTU:    res_d = word_t'(lt_u); // zero extended
			default: res_d = '0;
		endcase
	end

	// compare flag is less-than for sltu, equality otherwise
	assign cmp_d = (op_i == SLTU) ? lt_u : (a_i == b_i);

	//////////////////////////////
	// output stage
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (valid_i) begin
			res_o <= res_d ^ fault_res_i; // injected upset lands in the flop
			cmp_o <= cmp_d ^ fault_cmp_i;
		end
	end

endmodule : alu_core

`default_nettype wire

//--- spare_voter.sv
// 2-of-3 voter over four replicas; at most one lane_sel_i bit may be set, otherwise the spare is voted twice
`include "ft_alu_cfg.svh"
`default_nettype none

module spare_voter import ft_alu_pkg::*; #(
	parameter type payload_t = logic      // word_t for results, logic for the flag
) (
	input  payload_t [`FT_NREPL-1:0] val_i,      // one value per physical replica
	input  lane_sel_t                lane_sel_i, // lane -> spare mapping
	output payload_t                 voted_o,
	output repl_vec_t                disagree_o, // physical replicas that lost the vote
	output logic                     detected_o,
	output logic                     corrected_o
);

	localparam int SPARE = `FT_NREPL - 1; // spare is always the last replica

	payload_t lane [`FT_NLANE];
	logic     eq01;
	logic     eq02;
	logic     eq12;

	//////////////////////////////
	// lane muxes
	always_comb begin
		for (int l = 0; l < `FT_NLANE; l++) begin
			lane[l] = lane_sel_i[l] ? val_i[SPARE] : val_i[l];
		end
	end

	assign eq01 = (lane[0] == lane[1]);
	assign eq02 = (lane[0] == lane[2]);
	assign eq12 = (lane[1] == lane[2]);

	//////////////////////////////
	// majority
	// lane 0 wins when it has a partner, and also when all three differ
	always_comb begin
		if (eq01 || eq02) begin
			voted_o = lane[0];
		end else if (eq12) begin
			voted_o = lane[1];
		end else begin
			voted_o = lane[0]; // no majority
		end
	end

	assign detected_o  = !(eq01 && eq12);                  // some pair differs
	assign corrected_o = detected_o && (eq01 || eq02 || eq12); // a pair still agrees

	//////////////////////////////
	// per replica attribution
	always_comb begin
		disagree_o = '0;
		for (int r = 0; r < `FT_NLANE; r++) begin
			// own replica counts only while its lane still uses it
			disagree_o[r] = !lane_sel_i[r] && (val_i[r] != voted_o);
		end
		disagree_o[SPARE] = (|lane_sel_i) && (val_i[SPARE] != voted_o); // idle spare never blamed
	end

endmodule : spare_voter

`default_nettype wire

//--- ft_ctrl.sv
// error counters, fault flags, spare swap and apb slave; zero wait state apb, one swap only and never undone
`include "ft_alu_cfg.svh"
`default_nettype none

module ft_ctrl import ft_alu_pkg::*; (
	input  logic                  clk_i,
	input  logic                  arst_n_i,
	input  logic                  valid_i,    // voted outputs valid this cycle
	input  repl_vec_t             res_dis_i,  // result voter attribution
	input  repl_vec_t             cmp_dis_i,  // flag voter attribution
	input  logic                  res_det_i,
	input  logic                  res_cor_i,
	input  logic                  cmp_det_i,
	input  logic                  cmp_cor_i,
	input  logic                  psel_i,
	input  logic                  penable_i,
	input  logic                  pwrite_i,
	input  logic [`FT_APB_AW-1:0] paddr_i,
	input  word_t                 pwdata_i,
	output lane_sel_t             lane_sel_o, // to both voters
	output repl_vec_t             faulty_o,   // count at or above threshold
	output logic                  err_detected_o,
	output logic                  err_corrected_o,
	output word_t                 prdata_o,
	output logic                  pready_o,
	output logic                  pslverr_o
);

	localparam int   SPARE  = `FT_NREPL - 1;
	localparam int   IDXW   = $clog2(`FT_NREPL);
	localparam cnt_t THRESH = cnt_t'(`FT_PERM_THRESH);

	cnt_t [`FT_NREPL-1:0] cnt_q;     // one counter per replica
	cnt_t [`FT_NREPL-1:0] cnt_d;
	repl_vec_t            inc;       // replicas blamed this cycle
	repl_vec_t            wr_cnt;    // apb write strobe per counter
	repl_vec_t            faulty_d;  // flags as they will be after the edge
	lane_sel_t            lane_sel_d;
	logic                 found;     // lowest lane already picked
	logic                 access;    // apb access phase
	logic                 cnt_hit;
	logic                 sts_hit;
	logic [IDXW-1:0]      cnt_idx;

	//////////////////////////////
	// error flags
	assign err_detected_o  = valid_i && (res_det_i || cmp_det_i);
	assign err_corrected_o = err_detected_o && (!res_det_i || res_cor_i)
		&& (!cmp_det_i || cmp_cor_i); // every detecting voter also fixed it

	assign inc = valid_i ? (res_dis_i | cmp_dis_i) : '0;

	//////////////////////////////
	// apb decode
	assign access   = psel_i && penable_i;
	assign pready_o = 1'b1;                  // never stalls
	assign sts_hit  = (paddr_i == `FT_REG_STATUS);

	always_comb begin
		cnt_hit = 1'b1;
		cnt_idx = '0;
		case (paddr_i)
			`FT_REG_CNT0: cnt_idx = IDXW'(0);
			`FT_REG_CNT1: cnt_idx = IDXW'(1);
			`FT_REG_CNT2: cnt_idx = IDXW'(2);
			`FT_REG_CNT3: cnt_idx = IDXW'(3);
			default:      cnt_hit = 1'b0;
		endcase
	end

	// unmapped address, or any write to status
	assign pslverr_o = access && (!(cnt_hit || sts_hit) || (pwrite_i && sts_hit));

	always_comb begin
		wr_cnt = '0;
		if (access && pwrite_i && cnt_hit) begin
			wr_cnt[cnt_idx] = 1'b1;
		end
	end

	always_comb begin
		prdata_o = '0;
		if (access && !pwrite_i) begin
			if (sts_hit) begin
				prdata_o[`FT_NREPL-1:0]        = faulty_o;
				prdata_o[`FT_NREPL +: `FT_NLANE] = lane_sel_o;
			end else if (cnt_hit) begin
				prdata_o[`FT_CNT_W-1:0] = cnt_q[cnt_idx];
			end
		end
	end

	//////////////////////////////
	// counters and flags
	always_comb begin
		for (int r = 0; r < `FT_NREPL; r++) begin
			cnt_d[r] = cnt_q[r];
			if (wr_cnt[r]) begin
				cnt_d[r] = pwdata_i[`FT_CNT_W-1:0]; // apb beats a same cycle increment
			end else if (inc[r] && (cnt_q[r] != '1)) begin
				cnt_d[r] = cnt_q[r] + 1'b1;     // saturate at all ones
			end
			faulty_o[r] = (cnt_q[r] >= THRESH);
			faulty_d[r] = (cnt_d[r] >= THRESH);
		end
	end

	//////////////////////////////
	// spare swap
	always_comb begin
		lane_sel_d = lane_sel_o;
		found      = 1'b0;
		// spare must be idle and healthy
		if ((lane_sel_o == '0) && !faulty_d[SPARE]) begin
			for (int l = 0; l < `FT_NLANE; l++) begin
				if (!found && faulty_d[l] && !faulty_o[l]) begin
					lane_sel_d[l] = 1'b1; // newly broken lane moves to the spare
					found         = 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cnt_q      <= '0;
			lane_sel_o <= '0;
		end else begin
			cnt_q      <= cnt_d;
			lane_sel_o <= lane_sel_d;
		end
	end

endmodule : ft_ctrl

`default_nettype wire

//--- ft_alu_top.sv
// tmr alu stage with one spare; outputs follow valid_i by one cycle, no back-pressure on the alu path
`include "ft_alu_cfg.svh"
`default_nettype none

module ft_alu_top import ft_alu_pkg::*; (
	input  logic                         clk_i,
	input  logic                         arst_n_i,
	input  logic                         valid_i,
	input  alu_op_e                      op_i,
	input  word_t                        a_i,
	input  word_t                        b_i,
	input  word_t [`FT_NREPL-1:0]        fault_res_i, // per replica result masks
	input  repl_vec_t                    fault_cmp_i, // per replica flag flips
	input  logic                         psel_i,
	input  logic                         penable_i,
	input  logic                         pwrite_i,
	input  logic [`FT_APB_AW-1:0]        paddr_i,
	input  word_t                        pwdata_i,
	output logic                         valid_o,
	output word_t                        result_o,
	output logic                         cmp_o,
	output logic                         err_detected_o,
	output logic                         err_corrected_o,
	output repl_vec_t                    faulty_o,
	output word_t                        prdata_o,
	output logic                         pready_o,
	output logic                         pslverr_o
);

	repl_vec_t             rep_valid;  // replica valids, only replica 0 is used
	word_t [`FT_NREPL-1:0] rep_res;
	repl_vec_t             rep_cmp;
	lane_sel_t             lane_sel;
	repl_vec_t             res_dis;
	repl_vec_t             cmp_dis;
	logic                  res_det;
	logic                  res_cor;
	logic                  cmp_det;
	logic                  cmp_cor;

	//////////////////////////////
	// replicas
	for (genvar r = 0; r < `FT_NREPL; r++) begin : g_repl
		alu_core i_alu_core (
			.clk_i       ( clk_i          ),
			.arst_n_i    ( arst_n_i       ),
			.valid_i     ( valid_i        ),
			.op_i        ( op_i           ),
			.a_i         ( a_i            ),
			.b_i         ( b_i            ),
			.fault_res_i ( fault_res_i[r] ),
			.fault_cmp_i ( fault_cmp_i[r] ),
			.valid_o     ( rep_valid[r]   ),
			.res_o       ( rep_res[r]     ),
			.cmp_o       ( rep_cmp[r]     )
		);
	end

	assign valid_o = rep_valid[0];

	//////////////////////////////
	// voters
	spare_voter #(.payload_t(word_t)) i_res_voter (
		.val_i       ( rep_res  ),
		.lane_sel_i  ( lane_sel ),
		.voted_o     ( result_o ),
		.disagree_o  ( res_dis  ),
		.detected_o  ( res_det  ),
		.corrected_o ( res_cor  )
	);

	spare_voter #(.payload_t(logic)) i_cmp_voter (
		.val_i       ( rep_cmp  ),
		.lane_sel_i  ( lane_sel ),
		.voted_o     ( cmp_o    ),
		.disagree_o  ( cmp_dis  ),
		.detected_o  ( cmp_det  ),
		.corrected_o ( cmp_cor  )
	);

	ft_ctrl i_ft_ctrl (
		.clk_i           ( clk_i           ),
		.arst_n_i        ( arst_n_i        ),
		.valid_i         ( valid_o         ), // voted outputs live this cycle
		.res_dis_i       ( res_dis         ),
		.cmp_dis_i       ( cmp_dis         ),
		.res_det_i       ( res_det         ),
		.res_cor_i       ( res_cor         ),
		.cmp_det_i       ( cmp_det         ),
		.cmp_cor_i       ( cmp_cor         ),
		.psel_i          ( psel_i          ),
		.penable_i       ( penable_i       ),
		.pwrite_i        ( pwrite_i        ),
		.paddr_i         ( paddr_i         ),
		.pwdata_i        ( pwdata_i        ),
		.lane_sel_o      ( lane_sel        ),
		.faulty_o        ( faulty_o        ),
		.err_detected_o  ( err_detected_o  ),
		.err_corrected_o ( err_corrected_o ),
		.prdata_o        ( prdata_o        ),
		.pready_o        ( pready_o        ),
		.pslverr_o       ( pslverr_o       )
	);

endmodule : ft_alu_top

`default_nettype wire

//--- tb_ft_alu_assertions.sv
// concurrent checks bound into ft_ctrl; they assume the cnt_q counter array stays inside ft_ctrl
`include "ft_alu_cfg.svh"
`default_nettype none

module tb_ft_alu_assertions import ft_alu_pkg::*; (
	input  logic                 clk_i,
	input  logic                 arst_n_i,
	input  logic                 valid_i,
	input  lane_sel_t            lane_sel_o,
	input  logic                 pready_o,
	input  repl_vec_t            faulty_o,
	input  cnt_t [`FT_NREPL-1:0] cnt_q,      // internal counters of ft_ctrl
	input  logic                 err_detected_o,
	input  logic                 err_corrected_o
);

	timeunit 1ns;
	timeprecision 1ps;

	//////////////////////////////
	// spare use and apb
	a_one_spare: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		$onehot0(lane_sel_o)) else $error("more than one lane uses the spare");

	a_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		pready_o) else $error("pready_o dropped low");

	//////////////////////////////
	// flags
	for (genvar r = 0; r < `FT_NREPL; r++) begin : g_cnt
		a_faulty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
			faulty_o[r] |-> (cnt_q[r] >= cnt_t'(`FT_PERM_THRESH)))
			else $error("faulty flag set below the threshold");
	end

	a_err_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		!valid_i |-> (!err_detected_o && !err_corrected_o))
		else $error("error flag high without a valid op");

endmodule : tb_ft_alu_assertions

`default_nettype wire

//--- tb_ft_alu.sv
// testbench for ft_alu_top; one op per two cycles, apb accesses only while the alu path is idle
`include "ft_alu_cfg.svh"
`default_nettype none

module tb_ft_alu import ft_alu_pkg::*;;

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [2:0] RD_NONE = 3'd7; // no apb read after the op
	localparam logic [2:0] RD_STS  = 3'd4; // read status, 0..3 read a counter

	typedef struct packed {
		alu_op_e               op;
		word_t                 a;
		word_t                 b;
		logic                  rnd;  // operands from the xorshift
		word_t [`FT_NREPL-1:0] m;    // result masks per replica
		repl_vec_t             flip; // compare flips per replica
		logic [2:0]            rd;
	} entry_t;

	logic clk_i = 1'b0;
	logic arst_n_i = 1'b0;
	logic valid_i = 1'b0;
	alu_op_e op_i = ADD;
	word_t a_i = '0;
	word_t b_i = '0;
	word_t [`FT_NREPL-1:0] fault_res_i = '0;
	repl_vec_t fault_cmp_i = '0;
	logic psel_i = 1'b0;
	logic penable_i = 1'b0;
	logic pwrite_i = 1'b0;
	logic [`FT_APB_AW-1:0] paddr_i = '0;
	word_t pwdata_i = '0;
	logic valid_o, cmp_o, err_detected_o, err_corrected_o, pready_o, pslverr_o;
	word_t result_o, prdata_o;
	repl_vec_t faulty_o;

	entry_t tbl[$];
	cnt_t [`FT_NREPL-1:0] mcnt = '0; // model counters
	lane_sel_t msel = '0;             // model lane selection
	logic [31:0] rng = 32'h46e1;
	int mism = 0;
	int other = 0;
	int cycles = 0;
	int limit = 100000; // replaced once the table is built

	always #4 clk_i = ~clk_i; // 8 ns period

	ft_alu_top i_ft_alu_top (.*);

	bind ft_ctrl tb_ft_alu_assertions i_ctrl_props (
		.clk_i(clk_i), .arst_n_i(arst_n_i), .valid_i(valid_i), .lane_sel_o(lane_sel_o),
		.pready_o(pready_o), .faulty_o(faulty_o), .cnt_q(cnt_q),
		.err_detected_o(err_detected_o), .err_corrected_o(err_corrected_o)
	);

	//////////////////////////////
	// helpers
	function automatic word_t next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic word_t golden(input alu_op_e op, input word_t a, input word_t b);
		case (op)
			ADD: return a + b;
			SUB: return a - b;
			AND: return a & b;
			OR: return a | b;
			XOR: return a ^ b;
			SLL: return a << b[4:0]; // only five shift bits
			SRL: return a >> b[4:0];
			default: return (a < b) ? 32'd1 : 32'd0; // sltu
		endcase
	endfunction

	// 2 of 3, lane 0 when nobody agrees
	task automatic vote(input word_t v0, input word_t v1, input word_t v2,
		output word_t w, output logic det, output logic cor);
		w = (v0 == v1 || v0 == v2) ? v0 : ((v1 == v2) ? v1 : v0);
		det = (v0 != v1) || (v1 != v2);
		cor = det && ((v0 == v1) || (v0 == v2) || (v1 == v2));
	endtask

	function automatic repl_vec_t faulty_of(input cnt_t [`FT_NREPL-1:0] c);
		repl_vec_t f;
		for (int r = 0; r < `FT_NREPL; r++) f[r] = (c[r] >= cnt_t'(`FT_PERM_THRESH));
		return f;
	endfunction

	task automatic check(input string name, input word_t got, input word_t exp);
		assert (got === exp) else begin
			$display("MISMATCH t=%0t %s got %h exp %h", $time, name, got, exp);
			mism++;
		end
	endtask

	function automatic entry_t mk(input alu_op_e op, input word_t a, input word_t b,
		input logic rnd, input word_t [`FT_NREPL-1:0] m, input repl_vec_t flip,
		input logic [2:0] rd);
		return '{op: op, a: a, b: b, rnd: rnd, m: m, flip: flip, rd: rd};
	endfunction

	//////////////////////////////
	// apb, zero wait states
	task automatic apb_access(input logic wr, input logic [`FT_APB_AW-1:0] addr,
		input word_t wdata, input word_t exp, input logic exp_err);
		@(negedge clk_i);
		psel_i = 1'b1; // setup phase
		penable_i = 1'b0;
		pwrite_i = wr;
		paddr_i = addr;
		pwdata_i = wdata;
		@(negedge clk_i);
		penable_i = 1'b1;
		#2; // mid access phase
		check("pready_o", word_t'(pready_o), 32'd1);
		check("pslverr_o", word_t'(pslverr_o), word_t'(exp_err));
		if (!wr && !exp_err) check("prdata_o", prdata_o, exp);
		@(negedge clk_i);
		psel_i = 1'b0;
		penable_i = 1'b0;
	endtask

	function automatic word_t status_exp();
		return word_t'({msel, faulty_of(mcnt)});
	endfunction

	task automatic read_back(input logic [2:0] rd);
		if (rd == RD_STS) apb_access(1'b0, `FT_REG_STATUS, '0, status_exp(), 1'b0);
		else if (rd != RD_NONE) apb_access(1'b0, {3'b0, rd, 2'b0}, '0, word_t'(mcnt[rd]), 1'b0);
	endtask

	//////////////////////////////
	// one table entry
	task automatic run_entry(input entry_t e);
		word_t a, b, g, rw, cw;
		word_t rr [`FT_NREPL];
		word_t cc [`FT_NREPL];
		word_t ln [3];
		word_t lc [3];
		logic rdet, rcor, cdet, ccor, dexp;
		repl_vec_t dis, of, nf;
		logic found;
		a = e.a;
		b = e.b;
		if (e.rnd) begin
			a = next_rand();
			b = next_rand();
		end
		g = golden(e.op, a, b);
		for (int r = 0; r < `FT_NREPL; r++) begin
			rr[r] = g ^ e.m[r];
			cc[r] = word_t'((e.op == SLTU ? (a < b) : (a == b)) ^ e.flip[r]);
		end
		for (int l = 0; l < 3; l++) begin
			ln[l] = msel[l] ? rr[3] : rr[l]; // lane on spare or own replica
			lc[l] = msel[l] ? cc[3] : cc[l];
		end
		vote(ln[0], ln[1], ln[2], rw, rdet, rcor);
		vote(lc[0], lc[1], lc[2], cw, cdet, ccor);
		for (int r = 0; r < 3; r++) dis[r] = !msel[r] && (rr[r] != rw || cc[r] != cw);
		dis[3] = (|msel) && (rr[3] != rw || cc[3] != cw);
		dexp = rdet || cdet;
		@(negedge clk_i);
		valid_i = 1'b1;
		op_i = e.op;
		a_i = a;
		b_i = b;
		fault_res_i = e.m;
		fault_cmp_i = e.flip;
		@(negedge clk_i);
		valid_i = 1'b0;
		fault_res_i = '0;
		fault_cmp_i = '0;
		assert (valid_o === 1'b1) else begin
			$display("valid_o did not follow valid_i at t=%0t", $time);
			other++;
		end
		check("result_o", result_o, rw);
		check("cmp_o", word_t'(cmp_o), cw);
		check("err_detected_o", word_t'(err_detected_o), word_t'(dexp));
		check("err_corrected_o", word_t'(err_corrected_o),
			word_t'(dexp && (!rdet || rcor) && (!cdet || ccor)));
		// model of the counter edge that ends the valid_o cycle
		of = faulty_of(mcnt);
		check("faulty_o", word_t'(faulty_o), word_t'(of)); // flags before this edge
		for (int r = 0; r < `FT_NREPL; r++)
			if (dis[r] && mcnt[r] != 8'hff) mcnt[r] = mcnt[r] + 8'd1;
		nf = faulty_of(mcnt);
		found = 1'b0;
		if (msel == '0 && !nf[3]) begin
			for (int l = 0; l < 3; l++) begin
				if (!found && nf[l] && !of[l]) begin
					msel[l] = 1'b1; // lowest newly broken lane only
					found = 1'b1;
				end
			end
		end
		read_back(e.rd);
	endtask

	//////////////////////////////
	// cycle limit
	always @(posedge clk_i) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout after %0d cycles", cycles);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	initial begin
		// fault free, all eight ops
		tbl.push_back(mk(ADD, 32'd5, 32'd7, 1'b0, '0, 4'b0, RD_NONE));
		tbl.push_back(mk(ADD, 32'd42, 32'd42, 1'b0, '0, 4'b0, RD_NONE)); // equal operands
		tbl.push_back(mk(SUB, '0, '0, 1'b1, '0, 4'b0, RD_NONE));
		tbl.push_back(mk(AND, '0, '0, 1'b1, '0, 4'b0, RD_NONE));
		tbl.push_back(mk(OR, '0, '0, 1'b1, '0, 4'b0, RD_NONE));
		tbl.push_back(mk(XOR, '0, '0, 1'b1, '0, 4'b0, RD_NONE));
		tbl.push_back(mk(SLL, 32'd1, 32'd35, 1'b0, '0, 4'b0, RD_NONE)); // b[4:0] is 3
		tbl.push_back(mk(SRL, '0, '0, 1'b1, '0, 4'b0, RD_NONE));
		tbl.push_back(mk(SLTU, 32'd3, 32'd9, 1'b0, '0, 4'b0, RD_NONE));
		// single faults, corrected
		tbl.push_back(mk(ADD, '0, '0, 1'b1, {32'h0, 32'h100, 32'h0, 32'h0}, 4'b0, 3'd2));
		tbl.push_back(mk(SLTU, 32'd9, 32'd3, 1'b0, '0, 4'b0001, 3'd0));
		// two lanes wrong in different ways
		tbl.push_back(mk(XOR, '0, '0, 1'b1, {32'h0, 32'h0, 32'h2, 32'h1}, 4'b0, 3'd1));
		// replica 1 wears out, spare takes lane 1
		for (int i = 0; i < 4; i++)
			tbl.push_back(mk(alu_op_e'(i), '0, '0, 1'b1,
				{32'h0, 32'h0, 32'h8000_0000, 32'h0}, 4'b0, (i == 3) ? RD_STS : RD_NONE));
		tbl.push_back(mk(OR, '0, '0, 1'b1, {32'h40, 32'h0, 32'h0, 32'h0}, 4'b0, 3'd3));
		limit = 8 + tbl.size() * 8 + 40; // op, read and closing apb cycles plus margin

		repeat (8) @(posedge clk_i);
		@(negedge clk_i);
		arst_n_i = 1'b1;

		foreach (tbl[i]) run_entry(tbl[i]);

		// clear counter 1, spare stays in lane 1
		apb_access(1'b1, `FT_REG_CNT1, '0, '0, 1'b0);
		mcnt[1] = '0;
		check("faulty_o", word_t'(faulty_o), word_t'(faulty_of(mcnt)));
		apb_access(1'b0, `FT_REG_STATUS, '0, status_exp(), 1'b0);
		apb_access(1'b0, 8'h14, '0, '0, 1'b1);                  // unmapped
		apb_access(1'b1, `FT_REG_STATUS, 32'hffff, '0, 1'b1);  // read only
		apb_access(1'b0, `FT_REG_STATUS, '0, status_exp(), 1'b0);

		$display("errors: %0d mismatches, %0d other failures", mism, other);
		if (mism == 0 && other == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule : tb_ft_alu

`default_nettype wire

//--- sim.f
+incdir+.
ft_alu_pkg.sv
alu_core.sv
spare_voter.sv
ft_ctrl.sv
ft_alu_top.sv
tb_ft_alu_assertions.sv
tb_ft_alu.sv

//--- run_sim.sh
#!/bin/sh
# build and run the ft alu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_ft_alu \
	--Mdir obj_dir -o sim_ft_alu
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_ft_alu > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "^STATUS: PASS$" sim.log; then
	exit 0
fi
echo "pass line not found in sim.log"
exit 1
